/* build.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_ctrl.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/sdram_port.sv
rtl/cache_top.sv
tests/sdram_model.sv
tests/cache_tb.sv

/* Bender.yml */
package:
  name: dm_cache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/cache_ctrl.sv
      - rtl/tag_store.sv
      - rtl/line_store.sv
      - rtl/sdram_port.sv
      - rtl/cache_top.sv
  - target: test
    files:
      - tests/sdram_model.sv
      - tests/cache_tb.sv

/* tests/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

	localparam logic [31:0] SEED = 32'h90cc_d670;
	localparam int MAX_LAT = 5;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_REQUESTS = NUM_RANDOM + 6;
	// two transfers, lookup, process and extra hold cycles.
	localparam int WORST_CYCLES = 2 * (MAX_LAT + 4) + 12;
	localparam int TIMEOUT_CYCLES = NUM_REQUESTS * WORST_CYCLES + RESET_CYCLES + 10;

	logic clock = 1'b0;
	logic rst;
	logic request;
	logic rw;
	logic [31:0] address;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic o_ready;
	logic sdram_request;
	logic sdram_rw;
	logic [31:0] sdram_address;
	logic [127:0] sdram_wdata;
	logic [127:0] sdram_rdata;
	logic sdram_ready;

	logic [31:0] ref_mem [1024];
	logic ready_q;
	int cycles;
	int rd_count;
	int wr_count;
	int xfer_count;
	int last_wr_xfer;
	int last_rd_xfer;
	logic [31:0] last_wr_addr;
	logic [127:0] last_wr_line;
	int rd0;
	int wr0;
	int lat;
	integer seed;
	logic r_write;
	logic [31:0] r_addr;
	logic [31:0] r_data;
	int r_hold;

	cache_top dut_i (
		.i_clock(clock),
		.i_rst(rst),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(o_ready),
		.o_sdram_request(sdram_request),
		.o_sdram_rw(sdram_rw),
		.o_sdram_address(sdram_address),
		.o_sdram_wdata(sdram_wdata),
		.i_sdram_rdata(sdram_rdata),
		.i_sdram_ready(sdram_ready)
	);

	sdram_model #(.MAX_LATENCY(MAX_LAT), .SEED(SEED)) mem_i (
		.i_clock(clock),
		.i_rst(rst),
		.i_request(sdram_request),
		.i_rw(sdram_rw),
		.i_address(sdram_address),
		.i_wdata(sdram_wdata),
		.o_rdata(sdram_rdata),
		.o_ready(sdram_ready)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] pattern_word(input logic [31:0] word_addr);
		return (word_addr * 32'h9e37_79b9) ^ {word_addr[15:0], ~word_addr[15:0]};
	endfunction

	// reference memory view of one word.
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return ref_mem[addr[11:2]];
	endfunction

	function automatic logic [127:0] expected_line(input logic [31:0] addr);
		logic [127:0] line;
		for (int w = 0; w < 4; w++)
			line[w*32 +: 32] = ref_mem[addr[11:4] * 4 + w];
		return line;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %0h expected %0h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// one cpu request through the four-phase handshake.
	task automatic access(input logic is_write, input logic [31:0] addr,
		input logic [31:0] data, input int hold, output int latency);
		int n;
		n = 0;
		request <= 1'b1;
		rw <= is_write;
		address <= addr;
		wdata <= data;
		do begin
			@(posedge clock);
			n++;
		end while (!o_ready);
		latency = n - 2;
		if (is_write)
			ref_mem[addr[11:2]] = data;
		repeat (hold) @(posedge clock);
		request <= 1'b0;
		do @(posedge clock); while (o_ready);
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: the cache did not finish the requests within %0d cycles", cycles);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
	end

	// sdram transfer log.
	always @(posedge clock) begin
		if (sdram_request && sdram_ready) begin
			xfer_count <= xfer_count + 1;
			if (sdram_rw) begin
				wr_count <= wr_count + 1;
				last_wr_xfer <= xfer_count;
				last_wr_addr <= sdram_address;
				last_wr_line <= sdram_wdata;
			end
			else begin
				rd_count <= rd_count + 1;
				last_rd_xfer <= xfer_count;
			end
		end
	end

	// compare read data on each ready rise.
	always @(posedge clock) begin
		ready_q <= o_ready;
		if (o_ready && !ready_q && request && !rw) begin
			check_value("o_rdata", rdata, expected_word(address));
		end
	end

	initial begin
		seed = SEED;
		rst = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		ready_q = 1'b0;
		cycles = 0;
		rd_count = 0;
		wr_count = 0;
		xfer_count = 0;
		last_wr_xfer = 0;
		last_rd_xfer = 0;
		for (int i = 0; i < 1024; i++)
			ref_mem[i] = pattern_word(i);

		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		check_value("o_ready", o_ready, 0);
		check_value("o_sdram_request", sdram_request, 0);

		// cold miss since nothing is valid yet.
		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b0, 32'h0000_0100, 32'h0, 0, lat);
		check_value("sdram reads on cold miss", rd_count - rd0, 1);
		check_value("sdram writes on cold miss", wr_count - wr0, 0);

		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b0, 32'h0000_0104, 32'h0, 0, lat);
		check_value("hit latency", lat, 2);
		check_value("sdram transfers on hit", (rd_count - rd0) + (wr_count - wr0), 0);

		// clean victim at the same index.
		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b0, 32'h0000_0200, 32'h0, 1, lat);
		check_value("sdram reads on clean miss", rd_count - rd0, 1);
		check_value("sdram writes on clean miss", wr_count - wr0, 0);

		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b1, 32'h0000_0208, 32'hdead_beef, 0, lat);
		check_value("write hit latency", lat, 2);
		check_value("sdram transfers on write hit", (rd_count - rd0) + (wr_count - wr0), 0);

		// dirty victim goes back before the refill.
		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b0, 32'h0000_0308, 32'h0, 0, lat);
		check_value("sdram writes on dirty miss", wr_count - wr0, 1);
		check_value("sdram reads on dirty miss", rd_count - rd0, 1);
		check_value("o_sdram_address", last_wr_addr, 32'h0000_0200);
		check_value("o_sdram_wdata", last_wr_line, expected_line(32'h0000_0200));
		check_value("write before refill", last_wr_xfer < last_rd_xfer, 1);
		access(1'b0, 32'h0000_0208, 32'h0, 0, lat);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			r_addr = {$random(seed)} & 32'h0000_0ffc;
			r_data = $random(seed);
			r_write = ({$random(seed)} % 2) != 0;
			r_hold = {$random(seed)} % 3;
			access(r_write, r_addr, r_data, r_hold, lat);
		end

		$display("All checks passed");
		$finish;
	end

endmodule

/* tests/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model #(
	parameter int MAX_LATENCY = 5,
	parameter logic [31:0] SEED = 32'h90cc_d670
) (
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_request,
	input  logic i_rw,
	input  logic [31:0] i_address,
	input  logic [127:0] i_wdata,
	output logic [127:0] o_rdata,
	output logic o_ready
);

	// 4 KB of lines where higher address bits alias.
	logic [127:0] mem [256];
	logic [7:0] line_sel;
	logic busy;
	int count;
	integer seed;

	function automatic logic [31:0] fill_word(input logic [31:0] word_addr);
		return (word_addr * 32'h9e37_79b9) ^ {word_addr[15:0], ~word_addr[15:0]};
	endfunction

	assign line_sel = i_address[11:4];

	initial begin
		seed = SEED;
		o_ready = 1'b0;
		o_rdata = '0;
		for (int i = 0; i < 256; i++) begin
			for (int w = 0; w < 4; w++)
				mem[i][w*32 +: 32] = fill_word(i * 4 + w);
		end
	end

	always @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			busy <= 1'b0;
			count <= 0;
		end
		else if (!i_request) begin
			o_ready <= 1'b0;
			busy <= 1'b0;
		end
		else if (!o_ready) begin
			if (!busy) begin
				// new request draws its latency.
				busy <= 1'b1;
				count <= {$random(seed)} % (MAX_LATENCY + 1);
			end
			else if (count == 0) begin
				o_ready <= 1'b1;
				busy <= 1'b0;
				o_rdata <= mem[line_sel];
				if (i_rw)
					mem[line_sel] <= i_wdata;
			end
			else begin
				count <= count - 1;
			end
		end
	end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_top
	import cache_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_request,
	input  logic i_rw,
	input  logic [`CPU_ADDR_W-1:0] i_address,
	input  logic [`CPU_DATA_W-1:0] i_wdata,
	output logic [`CPU_DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_sdram_request,
	output logic o_sdram_rw,
	output logic [`CPU_ADDR_W-1:0] o_sdram_address,
	output logic [`LINE_W-1:0] o_sdram_wdata,
	input  logic [`LINE_W-1:0] i_sdram_rdata,
	input  logic i_sdram_ready
);

	cpu_req_t cpu_req;
	mem_req_t mem_req;
	mem_req_t sdram_req;
	logic hit;
	logic victim_valid;
	logic victim_dirty;
	logic [`CACHE_TAG_W-1:0] victim_tag;
	logic [`LINE_W-1:0] victim_line;
	logic [`LINE_W-1:0] refill_line;
	logic mem_start;
	logic mem_done;
	logic fill;
	logic mark_dirty;
	logic line_write;
	logic word_write;

	assign cpu_req.rw = i_rw;
	assign cpu_req.addr = addr_t'(i_address);
	assign cpu_req.wdata = i_wdata;

	assign o_sdram_rw = sdram_req.rw;
	assign o_sdram_address = {sdram_req.line_addr, {`CACHE_OFFSET_W{1'b0}}};
	assign o_sdram_wdata = sdram_req.wdata;

	cache_ctrl ctrl_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_req(cpu_req),
		.i_hit(hit),
		.i_victim_valid(victim_valid),
		.i_victim_dirty(victim_dirty),
		.i_victim_tag(victim_tag),
		.i_victim_line(victim_line),
		.i_mem_done(mem_done),
		.o_mem_start(mem_start),
		.o_mem_req(mem_req),
		.o_fill(fill),
		.o_mark_dirty(mark_dirty),
		.o_line_write(line_write),
		.o_word_write(word_write),
		.o_ready(o_ready)
	);

	tag_store tags_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_addr(cpu_req.addr),
		.i_fill(fill),
		.i_mark_dirty(mark_dirty),
		.o_hit(hit),
		.o_victim_valid(victim_valid),
		.o_victim_dirty(victim_dirty),
		.o_victim_tag(victim_tag)
	);

	line_store lines_i (
		.i_clock(i_clock),
		.i_addr(cpu_req.addr),
		.i_wdata(cpu_req.wdata),
		.i_line_write(line_write),
		.i_refill_line(refill_line),
		.i_word_write(word_write),
		.o_line(victim_line),
		.o_rdata(o_rdata)
	);

	sdram_port sdram_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_start(mem_start),
		.i_req(mem_req),
		.i_sdram_ready(i_sdram_ready),
		.i_sdram_rdata(i_sdram_rdata),
		.o_sdram_request(o_sdram_request),
		.o_sdram_req(sdram_req),
		.o_done(mem_done),
		.o_rline(refill_line)
	);

endmodule

/* rtl/sdram_port.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module sdram_port
	import cache_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_start,
	input  mem_req_t i_req,
	input  logic i_sdram_ready,
	input  logic [`LINE_W-1:0] i_sdram_rdata,
	output logic o_sdram_request,
	output mem_req_t o_sdram_req,
	output logic o_done,
	output logic [`LINE_W-1:0] o_rline
);

	logic accept;

	assign accept = o_sdram_request && i_sdram_ready;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_sdram_request <= 1'b0;
			o_done <= 1'b0;
		end
		else begin
			o_done <= accept;
			if (i_start)
				o_sdram_request <= 1'b1;
			else if (accept)
				o_sdram_request <= 1'b0;
		end
	end

	// request fields stay put for the whole transfer.
	always_ff @(posedge i_clock) begin
		if (i_start)
			o_sdram_req <= i_req;
	end

	// returned line is only valid in the ready cycle.
	always_ff @(posedge i_clock) begin
		if (accept)
			o_rline <= i_sdram_rdata;
	end

endmodule

/* rtl/line_store.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module line_store
	import cache_pkg::*;
(
	input  logic i_clock,
	input  addr_t i_addr,
	input  logic [`CPU_DATA_W-1:0] i_wdata,
	input  logic i_line_write,
	input  logic [`LINE_W-1:0] i_refill_line,
	input  logic i_word_write,
	output logic [`LINE_W-1:0] o_line,
	output logic [`CPU_DATA_W-1:0] o_rdata
);

	logic [`LINE_W-1:0] lines [`CACHE_LINES];
	logic [`CPU_DATA_W-1:0] sel_word;

	assign o_line = lines[i_addr.index];
	assign sel_word = o_line[i_addr.word * `CPU_DATA_W +: `CPU_DATA_W];

	always_ff @(posedge i_clock) begin
		if (i_line_write)
			lines[i_addr.index] <= i_refill_line;
		else if (i_word_write)
			lines[i_addr.index][i_addr.word * `CPU_DATA_W +: `CPU_DATA_W] <= i_wdata;
	end

	// read word follows the held address, frozen while the line changes.
	always_ff @(posedge i_clock) begin
		if (!i_line_write && !i_word_write)
			o_rdata <= sel_word;
	end

endmodule

/* rtl/tag_store.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module tag_store
	import cache_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  addr_t i_addr,
	input  logic i_fill,
	input  logic i_mark_dirty,
	output logic o_hit,
	output logic o_victim_valid,
	output logic o_victim_dirty,
	output logic [`CACHE_TAG_W-1:0] o_victim_tag
);

	logic [`CACHE_TAG_W-1:0] tags [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid;
	logic [`CACHE_LINES-1:0] dirty;

	// lookup for the index of the current request.
	assign o_victim_tag = tags[i_addr.index];
	assign o_victim_valid = valid[i_addr.index];
	assign o_victim_dirty = dirty[i_addr.index];
	assign o_hit = o_victim_valid && (o_victim_tag == i_addr.tag);

	always_ff @(posedge i_clock) begin
		if (i_fill)
			tags[i_addr.index] <= i_addr.tag;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			valid <= '0;
			dirty <= '0;
		end
		else begin
			if (i_fill) begin
				valid[i_addr.index] <= 1'b1;
				dirty[i_addr.index] <= 1'b0;
			end
			else if (i_mark_dirty) begin
				dirty[i_addr.index] <= 1'b1;
			end
		end
	end

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_ctrl
	import cache_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_request,
	input  cpu_req_t i_req,
	input  logic i_hit,
	input  logic i_victim_valid,
	input  logic i_victim_dirty,
	input  logic [`CACHE_TAG_W-1:0] i_victim_tag,
	input  logic [`LINE_W-1:0] i_victim_line,
	input  logic i_mem_done,
	output logic o_mem_start,
	output mem_req_t o_mem_req,
	output logic o_fill,
	output logic o_mark_dirty,
	output logic o_line_write,
	output logic o_word_write,
	output logic o_ready
);

	ctrl_state_t state;
	logic mem_busy;
	logic in_mem_state;
	logic refill_done;
	logic write_cycle;

	assign in_mem_state = (state == s_write_back) || (state == s_refill);

	// one start per sdram transfer.
	assign o_mem_start = in_mem_state && !mem_busy;

	assign refill_done = (state == s_refill) && i_mem_done;
	assign o_fill = refill_done;
	assign o_line_write = refill_done;

	assign write_cycle = (state == s_process) && i_req.rw;
	assign o_word_write = write_cycle;
	assign o_mark_dirty = write_cycle;

	always_comb begin
		o_mem_req = '0;
		if (state == s_write_back) begin
			// victim line goes back to where it came from.
			o_mem_req.rw = 1'b1;
			o_mem_req.line_addr = {i_victim_tag, i_req.addr.index};
			o_mem_req.wdata = i_victim_line;
		end
		else begin
			o_mem_req.rw = 1'b0;
			o_mem_req.line_addr = {i_req.addr.tag, i_req.addr.index};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= s_idle;
			mem_busy <= 1'b0;
			o_ready <= 1'b0;
		end
		else begin
			if (o_mem_start)
				mem_busy <= 1'b1;
			else if (i_mem_done)
				mem_busy <= 1'b0;

			case (state)
				s_idle: begin
					if (i_request)
						state <= s_lookup;
				end

				s_lookup: begin
					if (i_hit)
						state <= s_process;
					else if (i_victim_valid && i_victim_dirty)
						state <= s_write_back;
					else
						state <= s_refill;
				end

				s_write_back: begin
					if (i_mem_done)
						state <= s_refill;
				end

				s_refill: begin
					if (i_mem_done)
						state <= s_process;
				end

				s_process: begin
					o_ready <= 1'b1;
					state <= s_wait_end;
				end

				s_wait_end: begin
					// hold ready until the cpu lets go.
					if (!i_request) begin
						o_ready <= 1'b0;
						state <= s_idle;
					end
				end

				default:
					state <= s_idle;
			endcase
		end
	end

endmodule

/* rtl/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

	// overlays a cpu byte address.
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_WORD_W-1:0] word;
		logic [`CACHE_BYTE_W-1:0] byte_sel;
	} addr_t;

	typedef struct packed {
		logic rw;
		addr_t addr;
		logic [`CPU_DATA_W-1:0] wdata;
	} cpu_req_t;

	// line_addr is the byte address without the offset bits.
	typedef struct packed {
		logic rw;
		logic [`CACHE_LINE_ADDR_W-1:0] line_addr;
		logic [`LINE_W-1:0] wdata;
	} mem_req_t;

	typedef enum logic [2:0] {
		s_idle,
		s_lookup,
		s_write_back,
		s_refill,
		s_process,
		s_wait_end
	} ctrl_state_t;

endpackage

/* rtl/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// number of lines, a power of two.
`define CACHE_LINES 16

`define CACHE_INDEX_W $clog2(`CACHE_LINES)

// cpu side widths.
`define CPU_ADDR_W 32
`define CPU_DATA_W 32

// byte address split below the index.
`define CACHE_BYTE_W 2
`define CACHE_WORD_W 2
`define CACHE_OFFSET_W (`CACHE_WORD_W + `CACHE_BYTE_W)

`define CACHE_TAG_W (`CPU_ADDR_W - `CACHE_OFFSET_W - `CACHE_INDEX_W)

// one line holds four cpu words.
`define LINE_W 128
`define CACHE_LINE_ADDR_W (`CPU_ADDR_W - `CACHE_OFFSET_W)

`endif
